// File: imul_farm.f
+incdir+hw
hw/imul_op_pkg.sv
hw/imul_ctrl_pkg.sv
hw/imul_dispatch.sv
hw/imul_iter_lane.sv
hw/imul_collect.sv
hw/imul_farm_top.sv
dv/imul_farm_tb.sv

// File: Bender.yml
package:
  name: imul_farm

export_include_dirs:
  - hw

sources:
  # packages ahead of the modules that import them
  - include_dirs:
      - hw
    files:
      - hw/imul_op_pkg.sv
      - hw/imul_ctrl_pkg.sv
      - hw/imul_dispatch.sv
      - hw/imul_iter_lane.sv
      - hw/imul_collect.sv
      - hw/imul_farm_top.sv

  # testbench, top module imul_farm_tb
  - target: test
    include_dirs:
      - hw
    files:
      - dv/imul_farm_tb.sv

// File: dv/imul_farm_tb.sv
// testbench for the four-lane multiplier farm
// drives random and corner operands and checks them against a reference queue

`timescale 1ns/1ps

`include "imul_defines.svh"

module imul_farm_tb
  import imul_op_pkg::*;
();

  localparam int W            = `IMUL_WIDTH;
  localparam int LANES        = `IMUL_LANES;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int N_OPS        = 48;
  localparam int N_DIRECTED   = 10;
  // long enough that every lane finishes and holds before draining starts
  localparam int HOLD_CYCLES  = 48;
  localparam int WATCHDOG_NS  = N_OPS * 40 * CLK_PERIOD * 2;
  localparam realtime DRIVE_DELAY = 0.5;

  logic           clk = 1'b0;
  logic           reset;
  logic [W-1:0]   req_a;
  logic [W-1:0]   req_b;
  imul_op_e       req_op;
  logic           req_valid;
  logic           req_ready;
  logic [2*W-1:0] resp_result;
  logic           resp_valid;
  logic           resp_ready;

  // reference queue of {op, expected product} entries
  logic [2*W:0]   exp_q[$];
  logic [2*W-1:0] head_product;
  imul_op_e       head_op;
  int             exp_count = 0;
  int             resp_total = 0;
  int             cycle_cnt = 0;
  // cycles since reset was released
  int             post_cnt = 0;
  logic           hold_pending;
  logic [2*W-1:0] last_result;

  always #(CLK_PERIOD / 2) clk = ~clk;

  imul_farm_top dut (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_op      (req_op),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .resp_result (resp_result),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready)
  );

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // full-width product of sign-extended operands for signed requests
  function automatic logic [2*W-1:0] ref_product(
    input logic [W-1:0] a,
    input logic [W-1:0] b,
    input imul_op_e     op
  );
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    logic [2*W-1:0]        ua;
    logic [2*W-1:0]        ub;
    sa = {{W{a[W-1]}}, a};
    sb = {{W{b[W-1]}}, b};
    ua = {{W{1'b0}}, a};
    ub = {{W{1'b0}}, b};
    if (op == IMUL_OP_SS) begin
      return sa * sb;
    end else begin
      return ua * ub;
    end
  endfunction

  // corner cases as {op, a, b}
  function automatic logic [2*W:0] directed_operands(input int idx);
    case (idx)
      0:       return {IMUL_OP_SS, 32'h0000_0000, 32'h1234_5678};
      1:       return {IMUL_OP_SS, 32'hffff_ffff, 32'hffff_ffff};
      2:       return {IMUL_OP_SS, 32'hffff_ffff, 32'h0000_0007};
      3:       return {IMUL_OP_SS, 32'h8000_0000, 32'h8000_0000};
      4:       return {IMUL_OP_SS, 32'h8000_0000, 32'h0000_0001};
      5:       return {IMUL_OP_SS, 32'h7fff_ffff, 32'h8000_0000};
      6:       return {IMUL_OP_UU, 32'hffff_ffff, 32'hffff_ffff};
      7:       return {IMUL_OP_UU, 32'h0000_0000, 32'hffff_ffff};
      8:       return {IMUL_OP_UU, 32'h8000_0000, 32'h0000_0002};
      default: return {IMUL_OP_SS, 32'h0000_0001, 32'h8000_0000};
    endcase
  endfunction

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [2*W-1:0] expected,
                                 input logic [2*W-1:0] actual);
    $display("FAILED %s expected %h actual %h", name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_failure(input string what);
    $display("error: %s", what);
    stop_with_failure();
  endtask

  // holds the request until the dispatcher takes it
  task automatic send_request(input logic [W-1:0] a, input logic [W-1:0] b,
                              input imul_op_e op);
    logic taken;
    req_a     = a;
    req_b     = b;
    req_op    = op;
    req_valid = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      // ready is stable mid-cycle
      @(negedge clk);
      taken = req_ready;
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (reset) begin
      exp_q.delete();
      exp_count    <= 0;
      resp_total   <= 0;
      post_cnt     <= 0;
      hold_pending <= 1'b0;
    end else begin
      // drain first since latency keeps a push and a pop off the same entry
      if (resp_valid && resp_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      if (resp_valid && resp_ready) begin
        resp_total <= resp_total + 1;
      end
      if (req_valid && req_ready) begin
        exp_q.push_back({req_op, ref_product(req_a, req_b, req_op)});
      end
      exp_count <= exp_q.size();
      if (exp_q.size() > 0) begin
        head_product <= exp_q[0][2*W-1:0];
        head_op      <= imul_op_e'(exp_q[0][2*W]);
      end
      hold_pending <= resp_valid && !resp_ready;
      last_result  <= resp_result;
      post_cnt     <= post_cnt + 1;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  assert property (@(posedge clk) (reset && cycle_cnt > 0) |-> !resp_valid)
    else report_failure("resp_valid high during reset");
  assert property (@(posedge clk) (!reset && post_cnt == 0) |-> (!resp_valid && req_ready))
    else report_failure("wrong resp_valid or req_ready on the first cycle after reset");
  // opening burst takes one lane per cycle
  assert property (@(posedge clk) (!reset && post_cnt < LANES) |-> (req_valid && req_ready))
    else report_failure("request not accepted on a consecutive cycle after reset");
  assert property (@(posedge clk) disable iff (reset) (exp_count >= LANES) |-> !req_ready)
    else report_failure("req_ready high while every lane holds a request");
  assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready) |-> exp_count > 0)
    else report_failure("response transferred with no request outstanding");
  assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready && head_op == IMUL_OP_SS) |-> (resp_result == head_product))
    else report_mismatch("signed_product", $sampled(head_product), $sampled(resp_result));
  assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready && head_op == IMUL_OP_UU) |-> (resp_result == head_product))
    else report_mismatch("unsigned_product", $sampled(head_product), $sampled(resp_result));
  assert property (@(posedge clk) disable iff (reset) hold_pending |-> resp_valid)
    else report_failure("resp_valid dropped before the response transferred");
  assert property (@(posedge clk) disable iff (reset)
    hold_pending |-> (resp_result == last_result))
    else report_mismatch("hold_result", $sampled(last_result), $sampled(resp_result));

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  initial begin : stimulus
    logic [31:0] stim_state;
    logic [2*W:0] dir;
    int dir_idx;
    reset      = 1'b1;
    req_a      = '0;
    req_b      = '0;
    req_op     = IMUL_OP_SS;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    stim_state = 32'd80;
    dir_idx    = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    for (int i = 0; i < N_OPS; i++) begin
      // corner operands every fourth request
      if ((i % 4 == 2) && dir_idx < N_DIRECTED) begin
        dir = directed_operands(dir_idx);
        dir_idx++;
        send_request(dir[2*W-1:W], dir[W-1:0], imul_op_e'(dir[2*W]));
      end else begin
        stim_state = xorshift32(stim_state);
        dir[2*W-1:W] = stim_state;
        stim_state = xorshift32(stim_state);
        dir[W-1:0] = stim_state;
        stim_state = xorshift32(stim_state);
        send_request(dir[2*W-1:W], dir[W-1:0], imul_op_e'(stim_state[0]));
      end
      // occasional gap once the opening burst is done
      if (i >= LANES && stim_state[8:7] == 2'b00) begin
        req_valid = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
      end
    end
    req_valid = 1'b0;
    wait (resp_total == N_OPS);
    // idle cycles so a stray response still meets the checks
    repeat (8) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

  // back-pressure first and a random ready pattern after it
  initial begin : ready_driver
    logic [31:0] rdy_state;
    int cycles;
    rdy_state = 32'd80;
    cycles    = 0;
    wait (reset === 1'b0);
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      cycles++;
      if (cycles < HOLD_CYCLES) begin
        resp_ready = 1'b0;
      end else begin
        rdy_state  = xorshift32(rdy_state);
        resp_ready = (rdy_state[3:0] > 4'd5);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired, responses stalled after %0d of %0d", resp_total, N_OPS);
    stop_with_failure();
  end

endmodule

// File: hw/imul_farm_top.sv
// four-lane iterative multiplier farm
// dispatcher, generated shift-and-add lanes and an in-order collector

`timescale 1ns/1ps

`include "imul_defines.svh"

module imul_farm_top
  import imul_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,

  // request port
  input  logic [`IMUL_WIDTH-1:0]     req_a,
  input  logic [`IMUL_WIDTH-1:0]     req_b,
  input  imul_op_e                   req_op,
  input  logic                       req_valid,
  output logic                       req_ready,

  // response port
  output logic [2*`IMUL_WIDTH-1:0]   resp_result,
  output logic                       resp_valid,
  input  logic                       resp_ready
);

  // --------------------------------------------------
  // dispatcher to lanes
  // --------------------------------------------------

  logic [`IMUL_LANES-1:0]   lane_req_valid;
  logic [`IMUL_LANES-1:0]   lane_req_ready;
  logic [`IMUL_WIDTH-1:0]   lane_a;
  logic [`IMUL_WIDTH-1:0]   lane_b;
  imul_op_e                 lane_op;

  // lanes to collector
  logic [`IMUL_LANES-1:0]   lane_resp_valid;
  logic [`IMUL_LANES-1:0]   lane_resp_ready;
  logic [2*`IMUL_WIDTH-1:0] lane_result [`IMUL_LANES];

  imul_dispatch u_dispatch (
    .clk            (clk),
    .reset          (reset),
    .req_a          (req_a),
    .req_b          (req_b),
    .req_op         (req_op),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .lane_req_ready (lane_req_ready),
    .lane_req_valid (lane_req_valid),
    .lane_a         (lane_a),
    .lane_b         (lane_b),
    .lane_op        (lane_op)
  );

  // one lane per round-robin slot
  for (genvar i = 0; i < `IMUL_LANES; i++) begin : g_lane
    imul_iter_lane u_lane (
      .clk             (clk),
      .reset           (reset),
      .lane_req_valid  (lane_req_valid[i]),
      .lane_req_ready  (lane_req_ready[i]),
      .lane_a          (lane_a),
      .lane_b          (lane_b),
      .lane_op         (lane_op),
      .lane_resp_valid (lane_resp_valid[i]),
      .lane_resp_ready (lane_resp_ready[i]),
      .lane_result     (lane_result[i])
    );
  end

  imul_collect u_collect (
    .clk             (clk),
    .reset           (reset),
    .lane_resp_valid (lane_resp_valid),
    .lane_result     (lane_result),
    .lane_resp_ready (lane_resp_ready),
    .resp_valid      (resp_valid),
    .resp_result     (resp_result),
    .resp_ready      (resp_ready)
  );

endmodule

// File: hw/imul_collect.sv
// multiplier farm collector
// drains lane results in round-robin order so responses keep request order

`timescale 1ns/1ps

`include "imul_defines.svh"

module imul_collect
  import imul_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,

  // from the lanes
  input  logic [`IMUL_LANES-1:0]     lane_resp_valid,
  input  logic [2*`IMUL_WIDTH-1:0]   lane_result [`IMUL_LANES],
  output logic [`IMUL_LANES-1:0]     lane_resp_ready,

  // external response port
  output logic                       resp_valid,
  output logic [2*`IMUL_WIDTH-1:0]   resp_result,
  input  logic                       resp_ready
);

  // lane whose result leaves next
  lane_idx_t ptr_q;
  logic      drain;

  // --------------------------------------------------
  // response mux
  // --------------------------------------------------

  // the pointer only moves on a transfer, so valid and data hold
  assign resp_valid  = lane_resp_valid[ptr_q];
  assign resp_result = lane_result[ptr_q];
  assign drain       = resp_valid && resp_ready;

  // ready goes back to the selected lane only
  always_comb begin
    lane_resp_ready        = '0;
    lane_resp_ready[ptr_q] = resp_ready;
  end

  // --------------------------------------------------
  // pointer
  // --------------------------------------------------

  // same order as the dispatcher issued them
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
    end else if (drain) begin
      if (ptr_q == lane_idx_t'(`IMUL_LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: hw/imul_iter_lane.sv
// iterative shift-and-add multiplier lane
// one product bit per cycle over 32 cycles, signed via magnitudes and sign fix

`timescale 1ns/1ps

`include "imul_defines.svh"

module imul_iter_lane
  import imul_op_pkg::*;
  import imul_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,

  // request side, from the dispatcher
  input  logic                       lane_req_valid,
  output logic                       lane_req_ready,
  input  logic [`IMUL_WIDTH-1:0]     lane_a,
  input  logic [`IMUL_WIDTH-1:0]     lane_b,
  input  imul_op_e                   lane_op,

  // response side, to the collector
  output logic                       lane_resp_valid,
  input  logic                       lane_resp_ready,
  output logic [2*`IMUL_WIDTH-1:0]   lane_result
);

  localparam int W = `IMUL_WIDTH;

  // control
  lane_state_e            state_q;
  lane_state_e            state_d;
  logic [`IMUL_CNT_W-1:0] cnt_q;
  logic                   accept;
  logic                   drain;
  logic                   last_iter;

  // datapath
  logic [2*W-1:0]         mcand_q;
  logic [W-1:0]           mplier_q;
  logic [2*W-1:0]         psum_q;
  logic                   sign_q;

  // operand conditioning
  logic                   is_signed;
  logic                   a_neg;
  logic                   b_neg;
  logic [W-1:0]           a_mag;
  logic [W-1:0]           b_mag;

  // --------------------------------------------------
  // handshakes
  // --------------------------------------------------

  assign lane_req_ready  = (state_q == LANE_IDLE);
  assign lane_resp_valid = (state_q == LANE_DONE);

  assign accept    = lane_req_valid && lane_req_ready;
  assign drain     = lane_resp_valid && lane_resp_ready;
  assign last_iter = (cnt_q == '0);

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      LANE_IDLE: begin
        if (accept) begin
          state_d = LANE_CALC;
        end
      end
      // counter at zero means this is the 32nd step
      LANE_CALC: begin
        if (last_iter) begin
          state_d = LANE_DONE;
        end
      end
      LANE_DONE: begin
        if (drain) begin
          state_d = LANE_IDLE;
        end
      end
      default: begin
        state_d = LANE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= LANE_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        // 32 steps, counting down to zero
        cnt_q <= `IMUL_CNT_W'(W - 1);
      end else if (state_q == LANE_CALC) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // operand magnitudes
  // --------------------------------------------------

  // unsigned requests pass straight through
  assign is_signed = (lane_op == IMUL_OP_SS);
  assign a_neg     = is_signed && lane_a[W-1];
  assign b_neg     = is_signed && lane_b[W-1];

  // the most negative value maps to 2^(W-1) as an unsigned magnitude
  assign a_mag = a_neg ? (~lane_a + 1'b1) : lane_a;
  assign b_mag = b_neg ? (~lane_b + 1'b1) : lane_b;

  // --------------------------------------------------
  // shift-and-add datapath
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand_q  <= {{W{1'b0}}, a_mag};
      mplier_q <= b_mag;
      psum_q   <= '0;
      sign_q   <= a_neg ^ b_neg;
    end else if (state_q == LANE_CALC) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier_q[0]) begin
        psum_q <= psum_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // sign fix on the way out, stable while done
  assign lane_result = sign_q ? (~psum_q + 1'b1) : psum_q;

endmodule

// File: hw/imul_dispatch.sv
// multiplier farm dispatcher
// hands accepted requests to the lanes in strict round-robin order

`timescale 1ns/1ps

`include "imul_defines.svh"

module imul_dispatch
  import imul_op_pkg::*;
  import imul_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,

  // external request port
  input  logic [`IMUL_WIDTH-1:0]   req_a,
  input  logic [`IMUL_WIDTH-1:0]   req_b,
  input  imul_op_e                 req_op,
  input  logic                     req_valid,
  output logic                     req_ready,

  // towards the lanes
  input  logic [`IMUL_LANES-1:0]   lane_req_ready,
  output logic [`IMUL_LANES-1:0]   lane_req_valid,
  output logic [`IMUL_WIDTH-1:0]   lane_a,
  output logic [`IMUL_WIDTH-1:0]   lane_b,
  output imul_op_e                 lane_op
);

  // lane that gets the next request
  lane_idx_t ptr_q;
  logic      accept;

  // --------------------------------------------------
  // steering
  // --------------------------------------------------

  // only the selected lane's readiness is visible outside
  assign req_ready = lane_req_ready[ptr_q];
  assign accept    = req_valid && req_ready;

  // valid reaches the selected lane only
  always_comb begin
    lane_req_valid         = '0;
    lane_req_valid[ptr_q]  = req_valid;
  end

  // operands go to every lane, only the valid one loads them
  assign lane_a  = req_a;
  assign lane_b  = req_b;
  assign lane_op = req_op;

  // --------------------------------------------------
  // pointer
  // --------------------------------------------------

  // step by one per accepted request, wrap after the last lane
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q <= '0;
    end else if (accept) begin
      if (ptr_q == lane_idx_t'(`IMUL_LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: hw/imul_ctrl_pkg.sv
// multiplier farm internal control types
// lane FSM states and the round-robin pointer type

`include "imul_defines.svh"

package imul_ctrl_pkg;

  // --------------------------------------------------
  // lane FSM
  // --------------------------------------------------

  typedef enum logic [1:0] {
    // waiting for a request
    LANE_IDLE = 2'd0,
    // one shift-and-add step per cycle
    LANE_CALC = 2'd1,
    // product held until drained
    LANE_DONE = 2'd2
  } lane_state_e;

  // round-robin pointer, shared by dispatcher and collector
  typedef logic [$clog2(`IMUL_LANES)-1:0] lane_idx_t;

endpackage

// File: hw/imul_op_pkg.sv
// multiplier request operations
// opcode carried with each request into the lanes

package imul_op_pkg;

  // --------------------------------------------------
  // opcodes
  // --------------------------------------------------

  // one bit is enough for the two kept operations
  typedef enum logic {
    // signed x signed
    IMUL_OP_SS = 1'b0,
    // unsigned x unsigned
    IMUL_OP_UU = 1'b1
  } imul_op_e;

endpackage

// File: hw/imul_defines.svh
// multiplier farm shared sizes
// operand width, lane count and iteration counter width

`ifndef IMUL_DEFINES_SVH
`define IMUL_DEFINES_SVH

// --------------------------------------------------
// datapath sizing
// --------------------------------------------------

// operand width, product is twice this
`define IMUL_WIDTH 32

// --------------------------------------------------
// farm sizing
// --------------------------------------------------

// number of parallel lanes, 2, 4 or 8
`define IMUL_LANES 4

// iteration counter width, log2 of the operand width
`define IMUL_CNT_W 5

`endif
